// File: common/hps_pkg.sv
// shared bus types and command codes; widths follow the host firmware and must not change
package hps_pkg;

	////////////////////////////////
	// bus and payload types
	////////////////////////////////

	typedef logic [15:0] hps_word_t;
	typedef logic [15:0] hps_cmd_t;
	typedef logic [31:0] joy_t;
	typedef logic [63:0] status_t;
	typedef logic [26:0] ioctl_addr_t;
	typedef logic [7:0]  ioctl_byte_t;
	typedef logic [31:0] file_ext_t;
	typedef logic [3:0]  st_count_t;

	// download FSM
	typedef enum logic {
		DL_IDLE,
		DL_ACTIVE
	} dl_state_t;

	////////////////////////////////
	// user-I/O commands
	////////////////////////////////

	localparam hps_cmd_t CMD_CFG        = 16'h0001;
	localparam hps_cmd_t CMD_JOY0       = 16'h0002;
	localparam hps_cmd_t CMD_JOY1       = 16'h0003;
	localparam hps_cmd_t CMD_CFG_STR    = 16'h0014;
	localparam hps_cmd_t CMD_STATUS     = 16'h001E;
	localparam hps_cmd_t CMD_STATUS_REQ = 16'h0029;
	localparam hps_cmd_t CMD_MENUMASK   = 16'h002E;

	////////////////////////////////
	// file-I/O commands
	////////////////////////////////

	localparam hps_cmd_t FIO_FILE_TX     = 16'h0053;
	localparam hps_cmd_t FIO_FILE_TX_DAT = 16'h0054;
	localparam hps_cmd_t FIO_FILE_INDEX  = 16'h0055;
	localparam hps_cmd_t FIO_FILE_INFO   = 16'h0056;

	// upper nibble of the status request counter readback
	localparam logic [3:0] STREQ_TAG = 4'hA;

endpackage

// File: file_io/file_download.sv
// 8-bit download only; no stall, so the host must honour ioctl_wait before the next data word
`timescale 1ns/1ps

module file_download #(
	parameter int CFG_AW = 10
) (
	input  logic                 clk_sys,
	input  logic                 arst_n,
	input  logic                 fio_word,
	input  logic [CFG_AW-1:0]    word_idx,
	input  hps_pkg::hps_cmd_t    cmd,
	input  hps_pkg::hps_word_t   io_din,
	output logic                 ioctl_download,
	output logic                 ioctl_wr,
	output hps_pkg::ioctl_addr_t ioctl_addr,
	output hps_pkg::ioctl_byte_t ioctl_dout,
	output hps_pkg::hps_word_t   ioctl_index,
	output hps_pkg::file_ext_t   ioctl_file_ext
);
	import hps_pkg::*;

	dl_state_t   state;
	ioctl_addr_t addr;
	logic        arg_word;
	logic        data_word;
	logic        wr_pend;

	// word 0 is the only word with a zero index
	assign arg_word  = fio_word && (word_idx != '0);
	assign data_word = arg_word && (cmd == FIO_FILE_TX_DAT) && (state == DL_ACTIVE);

	assign ioctl_download = (state == DL_ACTIVE);

	//////////////////////////////
	// download FSM
	//////////////////////////////

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			state    <= DL_IDLE;
			wr_pend  <= 1'b0;
			ioctl_wr <= 1'b0;
		end else begin
			// byte and address land first, write strobe follows
			wr_pend  <= data_word;
			ioctl_wr <= wr_pend;
			if (arg_word && (cmd == FIO_FILE_TX) && (word_idx == CFG_AW'(1))) begin
				state <= (io_din != '0) ? DL_ACTIVE : DL_IDLE;
			end
		end
	end

	//////////////////////////////
	// address, data and file info
	//////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (arg_word) begin
			case (cmd)
				FIO_FILE_TX: begin
					if (word_idx == CFG_AW'(1)) begin
						addr <= '0;
					end else if (word_idx == CFG_AW'(2)) begin
						addr[15:0] <= io_din;
					end else if (word_idx == CFG_AW'(3)) begin
						addr[26:16] <= io_din[10:0];
					end
				end
				FIO_FILE_INDEX: ioctl_index <= io_din;
				FIO_FILE_INFO: begin
					// extension arrives high half first
					if (word_idx == CFG_AW'(1)) begin
						ioctl_file_ext[31:16] <= io_din;
					end else if (word_idx == CFG_AW'(2)) begin
						ioctl_file_ext[15:0] <= io_din;
					end
				end
				default: ;
			endcase
		end
		if (data_word) begin
			ioctl_addr <= addr;
			ioctl_dout <= io_din[7:0];
			addr       <= addr + 1'b1;
		end
	end

endmodule

// File: project.f
common/hps_pkg.sv
source/hps_frame.sv
user_io/user_io_regs.sv
user_io/user_io_readback.sv
file_io/file_download.sv
source/hps_io.sv
verification/hps_io_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the hps_io testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -Wno-fatal \
	--top-module hps_io_tb \
	--Mdir obj_dir -o hps_io_sim \
	-f project.f; then
	echo "verilator build failed"
	exit 1
fi

if ! ./obj_dir/hps_io_sim; then
	echo "simulation failed"
	exit 1
fi

echo "simulation passed"
exit 0

// File: source/hps_frame.sv
// host must never raise io_enable and fp_enable together; word numbers saturate at all ones
`timescale 1ns/1ps

module hps_frame #(
	parameter int CFG_AW = 10
) (
	input  logic               clk_sys,
	input  logic               arst_n,
	input  logic               io_enable,
	input  logic               fp_enable,
	input  logic               io_strobe,
	input  hps_pkg::hps_word_t io_din,
	output logic               uio_word,
	output logic               fio_word,
	output logic               word_first,
	output logic               uio_end,
	output logic [CFG_AW-1:0]  word_idx,
	output hps_pkg::hps_cmd_t  cmd
);
	import hps_pkg::*;

	logic              frame_on;
	logic              has_cmd;
	hps_cmd_t          cmd_q;
	logic [CFG_AW-1:0] word_cnt;
	logic              io_enable_q;

	assign frame_on = io_enable | fp_enable;

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			has_cmd     <= 1'b0;
			cmd_q       <= '0;
			word_cnt    <= '0;
			io_enable_q <= 1'b0;
		end else begin
			io_enable_q <= io_enable;
			// no frame open, forget the command
			if (!frame_on) begin
				has_cmd  <= 1'b0;
				cmd_q    <= '0;
				word_cnt <= '0;
			end else if (io_strobe) begin
				if (!has_cmd) begin
					has_cmd  <= 1'b1;
					cmd_q    <= io_din;
					word_cnt <= CFG_AW'(1);
				end else if (!(&word_cnt)) begin
					word_cnt <= word_cnt + 1'b1;
				end
			end
		end
	end

	assign uio_word   = io_strobe & io_enable;
	assign fio_word   = io_strobe & fp_enable;
	assign word_first = (uio_word | fio_word) & ~has_cmd;
	// first low cycle of io_enable
	assign uio_end    = io_enable_q & ~io_enable;
	// counter is zero until the command word has gone by
	assign word_idx   = word_cnt;
	assign cmd        = has_cmd ? cmd_q : io_din;

endmodule

// File: source/hps_io.sv
// single clock domain on clk_sys; host_wait is a plain copy of ioctl_wait, nothing is buffered
`timescale 1ns/1ps

module hps_io #(
	parameter int CFG_AW = 10
) (
	input  logic                 clk_sys,
	input  logic                 arst_n,
	// host bus
	input  logic                 io_enable,
	input  logic                 fp_enable,
	input  logic                 io_strobe,
	input  hps_pkg::hps_word_t   io_din,
	output hps_pkg::hps_word_t   io_dout,
	output logic                 host_wait,
	// config string memory
	output logic [CFG_AW-1:0]    cfg_addr,
	input  logic [7:0]           cfg_dout,
	// core controls
	output logic [1:0]           buttons,
	output logic                 forced_scandoubler,
	output logic                 direct_video,
	output hps_pkg::joy_t        joystick_0,
	output hps_pkg::joy_t        joystick_1,
	output hps_pkg::status_t     status,
	input  hps_pkg::status_t     status_in,
	input  logic                 status_set,
	input  hps_pkg::hps_word_t   status_menumask,
	// download stream
	output logic                 ioctl_download,
	output logic                 ioctl_wr,
	output hps_pkg::ioctl_addr_t ioctl_addr,
	output hps_pkg::ioctl_byte_t ioctl_dout,
	output hps_pkg::hps_word_t   ioctl_index,
	output hps_pkg::file_ext_t   ioctl_file_ext,
	input  logic                 ioctl_wait
);
	import hps_pkg::*;

	logic              uio_word;
	logic              fio_word;
	logic              word_first;
	logic              uio_end;
	logic [CFG_AW-1:0] word_idx;
	hps_cmd_t          cmd;
	status_t           status_req;
	st_count_t         st_count;

	assign host_wait = ioctl_wait;

	hps_frame #(.CFG_AW(CFG_AW)) hps_frame_inst (
		.clk_sys    (clk_sys),
		.arst_n     (arst_n),
		.io_enable  (io_enable),
		.fp_enable  (fp_enable),
		.io_strobe  (io_strobe),
		.io_din     (io_din),
		.uio_word   (uio_word),
		.fio_word   (fio_word),
		.word_first (word_first),
		.uio_end    (uio_end),
		.word_idx   (word_idx),
		.cmd        (cmd)
	);

	user_io_regs #(.CFG_AW(CFG_AW)) user_io_regs_inst (
		.clk_sys            (clk_sys),
		.arst_n             (arst_n),
		.uio_word           (uio_word),
		.word_first         (word_first),
		.uio_end            (uio_end),
		.word_idx           (word_idx),
		.cmd                (cmd),
		.io_din             (io_din),
		.status_in          (status_in),
		.status_set         (status_set),
		.cfg_bits           (buttons),
		.forced_scandoubler (forced_scandoubler),
		.direct_video       (direct_video),
		.joystick_0         (joystick_0),
		.joystick_1         (joystick_1),
		.status             (status),
		.status_req         (status_req),
		.st_count           (st_count)
	);

	user_io_readback #(.CFG_AW(CFG_AW)) user_io_readback_inst (
		.clk_sys         (clk_sys),
		.arst_n          (arst_n),
		.uio_word        (uio_word),
		.word_first      (word_first),
		.uio_end         (uio_end),
		.word_idx        (word_idx),
		.cmd             (cmd),
		.io_din          (io_din),
		.status_req      (status_req),
		.st_count        (st_count),
		.status_menumask (status_menumask),
		.cfg_dout        (cfg_dout),
		.io_dout         (io_dout),
		.cfg_addr        (cfg_addr)
	);

	file_download #(.CFG_AW(CFG_AW)) file_download_inst (
		.clk_sys        (clk_sys),
		.arst_n         (arst_n),
		.fio_word       (fio_word),
		.word_idx       (word_idx),
		.cmd            (cmd),
		.io_din         (io_din),
		.ioctl_download (ioctl_download),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.ioctl_index    (ioctl_index),
		.ioctl_file_ext (ioctl_file_ext)
	);

endmodule

// File: user_io/user_io_readback.sv
// config string memory must answer combinationally on cfg_addr; reads hold until the next strobe
`timescale 1ns/1ps

module user_io_readback #(
	parameter int CFG_AW = 10
) (
	input  logic               clk_sys,
	input  logic               arst_n,
	input  logic               uio_word,
	input  logic               word_first,
	input  logic               uio_end,
	input  logic [CFG_AW-1:0]  word_idx,
	input  hps_pkg::hps_cmd_t  cmd,
	input  hps_pkg::hps_word_t io_din,
	input  hps_pkg::status_t   status_req,
	input  hps_pkg::st_count_t st_count,
	input  hps_pkg::hps_word_t status_menumask,
	input  logic [7:0]         cfg_dout,
	output hps_pkg::hps_word_t io_dout,
	output logic [CFG_AW-1:0]  cfg_addr
);
	import hps_pkg::*;

	logic       quarter_arg;
	logic [5:0] quarter_sel;
	logic       streq_first;

	assign quarter_arg = (word_idx != '0) && (word_idx <= CFG_AW'(4));
	assign quarter_sel = {word_idx[1:0] - 2'd1, 4'b0000};

	// command word of a status request frame
	assign streq_first = word_first && (io_din == CMD_STATUS_REQ);

	// argument k of the string command reads byte k
	assign cfg_addr = word_idx;

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			io_dout <= '0;
		end else if (uio_end) begin
			io_dout <= '0;
		end else if (uio_word) begin
			io_dout <= '0;
			if (word_first) begin
				if (streq_first) begin
					io_dout <= {8'h00, STREQ_TAG, st_count};
				end
			end else begin
				case (cmd)
					CMD_STATUS_REQ: begin
						if (quarter_arg) begin
							io_dout <= status_req[quarter_sel +: 16];
						end
					end
					CMD_MENUMASK: begin
						if (word_idx == CFG_AW'(1)) begin
							io_dout <= status_menumask;
						end
					end
					CMD_CFG_STR: io_dout <= {8'h00, cfg_dout};
					default: ;
				endcase
			end
		end
	end

endmodule

// File: user_io/user_io_regs.sv
// status_set is sampled on clk_sys and must be synchronous to it; the counter wraps at 16
`timescale 1ns/1ps

module user_io_regs #(
	parameter int CFG_AW = 10
) (
	input  logic                clk_sys,
	input  logic                arst_n,
	input  logic                uio_word,
	input  logic                word_first,
	input  logic                uio_end,
	input  logic [CFG_AW-1:0]   word_idx,
	input  hps_pkg::hps_cmd_t   cmd,
	input  hps_pkg::hps_word_t  io_din,
	input  hps_pkg::status_t    status_in,
	input  logic                status_set,
	output logic [1:0]          cfg_bits,
	output logic                forced_scandoubler,
	output logic                direct_video,
	output hps_pkg::joy_t       joystick_0,
	output hps_pkg::joy_t       joystick_1,
	output hps_pkg::status_t    status,
	output hps_pkg::status_t    status_req,
	output hps_pkg::st_count_t  st_count
);
	import hps_pkg::*;

	logic       cmd_open;
	logic       arg_word;
	logic       quarter_arg;
	logic [5:0] quarter_sel;
	logic       status_set_q;
	logic       set_rise;

	// arguments only count inside a frame whose command we saw
	assign arg_word = uio_word & ~word_first & cmd_open;

	// arguments 1 to 4 map onto the four 16-bit quarters
	assign quarter_arg = (word_idx != '0) && (word_idx <= CFG_AW'(4));
	assign quarter_sel = {word_idx[1:0] - 2'd1, 4'b0000};

	assign set_rise = status_set & ~status_set_q;

	//////////////////////////////
	// host writes
	//////////////////////////////

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			cmd_open           <= 1'b0;
			cfg_bits           <= '0;
			forced_scandoubler <= 1'b0;
			direct_video       <= 1'b0;
			joystick_0         <= '0;
			joystick_1         <= '0;
			status             <= '0;
		end else begin
			if (uio_end) begin
				cmd_open <= 1'b0;
			end else if (uio_word && word_first) begin
				cmd_open <= 1'b1;
			end

			if (arg_word) begin
				case (cmd)
					CMD_CFG: begin
						cfg_bits           <= io_din[1:0];
						forced_scandoubler <= io_din[4];
						direct_video       <= io_din[10];
					end
					CMD_JOY0: begin
						if (word_idx == CFG_AW'(1)) begin
							joystick_0[15:0] <= io_din;
						end else begin
							joystick_0[31:16] <= io_din;
						end
					end
					CMD_JOY1: begin
						if (word_idx == CFG_AW'(1)) begin
							joystick_1[15:0] <= io_din;
						end else begin
							joystick_1[31:16] <= io_din;
						end
					end
					CMD_STATUS: begin
						if (quarter_arg) begin
							status[quarter_sel +: 16] <= io_din;
						end
					end
					default: ;
				endcase
			end
		end
	end

	//////////////////////////////
	// core status requests
	//////////////////////////////

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			status_set_q <= 1'b0;
			st_count     <= '0;
		end else begin
			status_set_q <= status_set;
			if (set_rise) begin
				st_count <= st_count + 1'b1;
			end
		end
	end

	// snapshot of status_in, read back by the host
	always_ff @(posedge clk_sys) begin
		if (set_rise) begin
			status_req <= status_in;
		end
	end

endmodule

// File: verification/hps_io_tb.sv
// single clk_sys domain; the config string memory is an asynchronous testbench array
`timescale 1ns/1ps

module hps_io_tb;
	import hps_pkg::*;

	localparam int CFG_AW       = 10;
	localparam int CLK_HALF     = 20;
	localparam int RESET_CYCLES = 4;
	localparam int WORD_CYCLES  = 4;
	localparam int FRAME_CYCLES = 3;
	localparam int NUM_WORDS    = 52;
	localparam int NUM_FRAMES   = 14;
	// status_set pulses, wait pin toggles and the write drain
	localparam int EXTRA_CYCLES = 24;
	localparam int TEST_CYCLES  = RESET_CYCLES + NUM_WORDS * WORD_CYCLES
		+ NUM_FRAMES * FRAME_CYCLES + EXTRA_CYCLES;
	localparam int CYCLE_LIMIT  = 2 * TEST_CYCLES;

	logic                clk_sys = 1'b0;
	logic                arst_n;
	logic                io_enable;
	logic                fp_enable;
	logic                io_strobe;
	hps_word_t           io_din;
	hps_word_t           io_dout;
	logic                host_wait;
	logic [CFG_AW-1:0]   cfg_addr;
	logic [7:0]          cfg_dout;
	logic [1:0]          buttons;
	logic                forced_scandoubler;
	logic                direct_video;
	joy_t                joystick_0;
	joy_t                joystick_1;
	status_t             status;
	status_t             status_in;
	logic                status_set;
	hps_word_t           status_menumask;
	logic                ioctl_download;
	logic                ioctl_wr;
	ioctl_addr_t         ioctl_addr;
	ioctl_byte_t         ioctl_dout;
	hps_word_t           ioctl_index;
	file_ext_t           ioctl_file_ext;
	logic                ioctl_wait;

	logic [31:0]         lfsr_state;
	logic [7:0]          cfg_mem [0:(1<<CFG_AW)-1];
	int                  cycle_count = 0;
	int                  wr_count = 0;
	logic                frame_user;
	hps_cmd_t            cur_cmd;
	int                  word_no;

	// reference model state
	logic [1:0]          m_buttons;
	logic                m_fsd;
	logic                m_dv;
	joy_t                m_joy0;
	joy_t                m_joy1;
	status_t             m_status;
	status_t             m_status_req;
	st_count_t           m_count;
	logic                m_download;
	ioctl_addr_t         m_addr;
	hps_word_t           m_index;
	file_ext_t           m_ext;
	ioctl_addr_t         exp_addr_q[$];
	ioctl_byte_t         exp_byte_q[$];
	// clock cycle in which each write pulse is due
	int                  exp_cycle_q[$];

	always #CLK_HALF clk_sys = ~clk_sys;

	assign cfg_dout = cfg_mem[cfg_addr];

	hps_io #(.CFG_AW(CFG_AW)) hps_io_inst (
		.clk_sys            (clk_sys),
		.arst_n             (arst_n),
		.io_enable          (io_enable),
		.fp_enable          (fp_enable),
		.io_strobe          (io_strobe),
		.io_din             (io_din),
		.io_dout            (io_dout),
		.host_wait          (host_wait),
		.cfg_addr           (cfg_addr),
		.cfg_dout           (cfg_dout),
		.buttons            (buttons),
		.forced_scandoubler (forced_scandoubler),
		.direct_video       (direct_video),
		.joystick_0         (joystick_0),
		.joystick_1         (joystick_1),
		.status             (status),
		.status_in          (status_in),
		.status_set         (status_set),
		.status_menumask    (status_menumask),
		.ioctl_download     (ioctl_download),
		.ioctl_wr           (ioctl_wr),
		.ioctl_addr         (ioctl_addr),
		.ioctl_dout         (ioctl_dout),
		.ioctl_index        (ioctl_index),
		.ioctl_file_ext     (ioctl_file_ext),
		.ioctl_wait         (ioctl_wait)
	);

	//////////////////////////////
	// helpers
	//////////////////////////////

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Test failed");
		$fatal(1, "run stopped on error");
	endtask

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] want);
		if (got !== want) begin
			abort_run($sformatf("Fail %s got 0x%0h expected 0x%0h", name, got, want));
		end
	endtask

	// galois form with taps for x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'h80200003;
		end else begin
			return s >> 1;
		end
	endfunction

	task automatic random_bits(input int n, output logic [63:0] val);
		val = '0;
		for (int i = 0; i < n; i++) begin
			val = {val[62:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	task automatic random_word(output hps_word_t w);
		logic [63:0] r;
		random_bits(16, r);
		w = r[15:0];
	endtask

	// expected host read word for one strobe
	function automatic hps_word_t ref_dout(input hps_cmd_t c, input int idx,
		input hps_word_t din);
		if (!frame_user) begin
			return 16'h0000;
		end
		if (idx == 0) begin
			if (din == CMD_STATUS_REQ) begin
				return {8'h00, STREQ_TAG, m_count};
			end
			return 16'h0000;
		end
		if (c == CMD_STATUS_REQ && idx <= 4) begin
			return m_status_req[(idx-1)*16 +: 16];
		end
		if (c == CMD_MENUMASK && idx == 1) begin
			return status_menumask;
		end
		if (c == CMD_CFG_STR) begin
			return {8'h00, cfg_mem[idx]};
		end
		return 16'h0000;
	endfunction

	task automatic model_write(input hps_cmd_t c, input int idx, input hps_word_t din);
		if (idx != 0 && frame_user) begin
			case (c)
				CMD_CFG: begin
					m_buttons = din[1:0];
					m_fsd     = din[4];
					m_dv      = din[10];
				end
				CMD_JOY0: begin
					if (idx == 1) m_joy0[15:0] = din;
					else m_joy0[31:16] = din;
				end
				CMD_JOY1: begin
					if (idx == 1) m_joy1[15:0] = din;
					else m_joy1[31:16] = din;
				end
				CMD_STATUS: begin
					if (idx <= 4) m_status[(idx-1)*16 +: 16] = din;
				end
				default: ;
			endcase
		end else if (idx != 0) begin
			case (c)
				FIO_FILE_TX: begin
					if (idx == 1) begin
						m_download = (din != 16'h0000);
						m_addr     = '0;
					end else if (idx == 2) begin
						m_addr[15:0] = din;
					end else if (idx == 3) begin
						m_addr[26:16] = din[10:0];
					end
				end
				FIO_FILE_TX_DAT: begin
					if (m_download) begin
						exp_addr_q.push_back(m_addr);
						exp_byte_q.push_back(din[7:0]);
						exp_cycle_q.push_back(cycle_count + 2);
						m_addr = m_addr + 27'd1;
					end
				end
				FIO_FILE_INDEX: m_index = din;
				FIO_FILE_INFO: begin
					if (idx == 1) m_ext[31:16] = din;
					else if (idx == 2) m_ext[15:0] = din;
				end
				default: ;
			endcase
		end
	endtask

	task automatic check_regs();
		check_value("buttons", buttons, m_buttons);
		check_value("forced_scandoubler", forced_scandoubler, m_fsd);
		check_value("direct_video", direct_video, m_dv);
		check_value("joystick_0", joystick_0, m_joy0);
		check_value("joystick_1", joystick_1, m_joy1);
		check_value("status", status, m_status);
		check_value("ioctl_download", ioctl_download, m_download);
	endtask

	task automatic open_frame(input logic user);
		@(negedge clk_sys);
		io_enable  = user;
		fp_enable  = ~user;
		frame_user = user;
		word_no    = 0;
	endtask

	task automatic close_frame();
		@(negedge clk_sys);
		io_enable = 1'b0;
		fp_enable = 1'b0;
		@(negedge clk_sys);
		check_value("io_dout", io_dout, 64'h0);
	endtask

	// one strobe followed by a gap of three cycles
	task automatic send_word(input hps_word_t w);
		hps_word_t want;
		@(negedge clk_sys);
		if (word_no == 0) cur_cmd = w;
		want = ref_dout(cur_cmd, word_no, w);
		model_write(cur_cmd, word_no, w);
		io_din    = w;
		io_strobe = 1'b1;
		@(negedge clk_sys);
		io_strobe = 1'b0;
		check_value("io_dout", io_dout, want);
		check_regs();
		word_no++;
		repeat (2) @(negedge clk_sys);
	endtask

	task automatic pulse_status_set(input status_t v);
		@(negedge clk_sys);
		status_in    = v;
		status_set   = 1'b1;
		m_status_req = v;
		m_count      = m_count + 4'd1;
		@(negedge clk_sys);
		status_set = 1'b0;
	endtask

	//////////////////////////////
	// write stream checker and timeout
	//////////////////////////////

	always @(negedge clk_sys) begin
		if (arst_n && ioctl_wr) begin
			if (exp_byte_q.size() == 0) begin
				abort_run("ioctl_wr pulsed with no download byte pending");
			end else begin
				check_value("ioctl_wr cycle", cycle_count, exp_cycle_q.pop_front());
				check_value("ioctl_addr", ioctl_addr, exp_addr_q.pop_front());
				check_value("ioctl_dout", ioctl_dout, exp_byte_q.pop_front());
				wr_count++;
			end
		end
	end

	always @(posedge clk_sys) begin
		cycle_count++;
		if (cycle_count >= CYCLE_LIMIT) begin
			abort_run($sformatf("timeout, run still busy after %0d cycles", cycle_count));
		end
	end

	//////////////////////////////
	// stimulus
	//////////////////////////////

	initial begin
		hps_word_t   w;
		logic [63:0] r;
		logic [31:0] status_hi;
		arst_n = 1'b0;
		io_enable = 1'b0;
		fp_enable = 1'b0;
		io_strobe = 1'b0;
		io_din = '0;
		status_in = '0;
		status_set = 1'b0;
		ioctl_wait = 1'b0;
		frame_user = 1'b0;
		cur_cmd = '0;
		word_no = 0;
		{m_buttons, m_fsd, m_dv, m_joy0, m_joy1, m_status} = '0;
		{m_status_req, m_count, m_download, m_addr, m_index, m_ext} = '0;
		lfsr_state = 32'h73d43f52;
		for (int a = 0; a < (1 << CFG_AW); a++) begin
			random_bits(8, r);
			cfg_mem[a] = r[7:0];
		end
		random_word(status_menumask);

		// reset values
		repeat (RESET_CYCLES) @(negedge clk_sys);
		arst_n = 1'b1;
		@(negedge clk_sys);
		check_value("io_dout", io_dout, 64'h0);
		check_value("cfg_addr", cfg_addr, 64'h0);
		check_value("ioctl_wr", ioctl_wr, 64'h0);
		check_regs();

		// configuration and joysticks
		open_frame(1'b1);
		send_word(CMD_CFG);
		random_word(w);
		send_word(w);
		close_frame();
		for (int j = 0; j < 2; j++) begin
			open_frame(1'b1);
			send_word((j == 0) ? CMD_JOY0 : CMD_JOY1);
			random_word(w);
			send_word(w);
			random_word(w);
			send_word(w);
			close_frame();
		end

		// status word and core status requests
		open_frame(1'b1);
		send_word(CMD_STATUS);
		repeat (4) begin
			random_word(w);
			send_word(w);
		end
		close_frame();
		repeat (3) begin
			random_bits(64, r);
			pulse_status_set(r);
		end
		open_frame(1'b1);
		send_word(CMD_STATUS_REQ);
		repeat (4) send_word(16'h0000);
		close_frame();

		// config string bytes 1 to 8, then the menu mask
		open_frame(1'b1);
		send_word(CMD_CFG_STR);
		repeat (8) send_word(16'h0000);
		close_frame();
		open_frame(1'b1);
		send_word(CMD_MENUMASK);
		send_word(16'h0000);
		close_frame();

		// download with index and extension
		open_frame(1'b0);
		send_word(FIO_FILE_INDEX);
		random_word(w);
		send_word(w);
		close_frame();
		check_value("ioctl_index", ioctl_index, m_index);
		open_frame(1'b0);
		send_word(FIO_FILE_INFO);
		random_word(w);
		send_word(w);
		random_word(w);
		send_word(w);
		close_frame();
		check_value("ioctl_file_ext", ioctl_file_ext, m_ext);
		open_frame(1'b0);
		send_word(FIO_FILE_TX);
		send_word(16'h0001);
		random_word(w);
		send_word(w);
		random_word(w);
		send_word(w);
		close_frame();
		open_frame(1'b0);
		send_word(FIO_FILE_TX_DAT);
		repeat (6) begin
			random_word(w);
			send_word(w);
		end
		close_frame();
		while (wr_count < 6) @(negedge clk_sys);
		open_frame(1'b0);
		send_word(FIO_FILE_TX);
		send_word(16'h0000);
		close_frame();
		@(negedge clk_sys);
		ioctl_wait = 1'b1;
		@(negedge clk_sys);
		check_value("host_wait", host_wait, 64'h1);
		ioctl_wait = 1'b0;
		@(negedge clk_sys);
		check_value("host_wait", host_wait, 64'h0);

		// frame cut after two status arguments
		status_hi = m_status[63:32];
		open_frame(1'b1);
		send_word(CMD_STATUS);
		random_word(w);
		send_word(w);
		random_word(w);
		send_word(w);
		close_frame();
		open_frame(1'b1);
		send_word(CMD_CFG);
		random_word(w);
		send_word(w);
		close_frame();
		check_value("status[63:32]", status[63:32], status_hi);

		@(negedge clk_sys);
		$display("Test completed successfully");
		$finish;
	end

endmodule
